// ==== gather_pkg.sv ====
/*
  Shared widths, burst sizes and types of the two-lane burst gatherer.
  Burst lengths are carried as element count minus one. A length field
  is always at least one bit wide, even for a single-element lane.
*/
`default_nettype none

package gather_pkg;

  // ************************************************************
  // helpers
  // ************************************************************

  // ceiling log2 that never returns zero.
  function automatic int safe_clog2(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // ************************************************************
  // lane geometry
  // ************************************************************

  localparam int DATA_W   = 16; // bits per data word.
  localparam int DATA_ELS = 4;  // longest data burst.
  localparam int TAG_W    = 8;  // bits per tag byte.
  localparam int TAG_ELS  = 2;  // longest tag burst.

  typedef logic [DATA_W-1:0] data_word_t;
  typedef logic [TAG_W-1:0]  tag_word_t;

  // count minus one, so 0 means a single element.
  typedef logic [safe_clog2(DATA_ELS)-1:0] data_len_t;
  typedef logic [safe_clog2(TAG_ELS)-1:0]  tag_len_t;

endpackage

`default_nettype wire

// ==== sipo_dynamic.sv ====
/*
  Serial-in, parallel-out deserializer with a per-burst length.
  len_i is sampled with the first word of a burst (len_ready_o high).
  The last word of a burst is not registered: it shows on data_o in the
  same cycle, so the sender must hold it until ready_o is seen high.
  Slots above the burst length are undefined. MAX_ELS of 1 is a plain
  passthrough and ignores len_i.
*/
`default_nettype none

module sipo_dynamic #(
  parameter type elem_t  = logic [7:0],
  parameter int  MAX_ELS = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_i,

  input  logic                                        v_i,
  input  elem_t                                       data_i,
  input  logic [gather_pkg::safe_clog2(MAX_ELS)-1:0]  len_i,
  output logic                                        ready_o,
  output logic                                        len_ready_o,

  output logic                                        v_o,
  output elem_t [MAX_ELS-1:0]                         data_o,
  input  logic                                        ready_i
);

  import gather_pkg::*;

  typedef logic [safe_clog2(MAX_ELS)-1:0] len_t;

  if (MAX_ELS == 1)
  begin : g_single

    // every word is a whole burst.
    assign v_o         = v_i;
    assign data_o[0]   = data_i;
    assign ready_o     = ready_i;
    assign len_ready_o = 1'b1;

  end
  else
  begin : g_multi

    len_t                  count_r;     // index of the next element.
    len_t                  len_r;       // length of the burst in progress.
    logic                  zero_cnt;
    logic                  last_cnt;
    logic                  zero_len;
    logic                  waiting;
    logic                  len_en;
    logic                  up;
    logic                  clear;
    logic [MAX_ELS-2:0]    we;
    elem_t [MAX_ELS-2:0]   store_r;

    // ************************************************************
    // burst state decode
    // ************************************************************

    assign zero_cnt = (count_r == len_t'(0));
    assign last_cnt = ~zero_cnt & (count_r == len_r);
    assign zero_len = v_i & zero_cnt & (len_i == len_t'(0));  // single-word burst.

    // a length-0 burst taken under back-pressure parks here.
    assign waiting  = ~zero_cnt & (len_r == len_t'(0));

    assign v_o         = (v_i & last_cnt) | zero_len | waiting;
    assign ready_o     = (ready_i | ~last_cnt) & ~waiting;
    assign len_ready_o = zero_cnt;

    assign clear  = v_o & ready_i;                  // output transfer ends the burst.
    assign up     = v_i & ready_o & ~clear;
    assign len_en = v_i & ready_o & zero_cnt;

    // ************************************************************
    // counter and length register
    // ************************************************************

    always_ff @(posedge clk_i)
    begin
      if (rst_i)
      begin
        count_r <= '0;
        len_r   <= '0;
      end
      else
      begin
        if (len_en)
          len_r <= len_i;
        if (clear)
          count_r <= '0;
        else if (up)
          count_r <= count_r + len_t'(1);
      end
    end

    // ************************************************************
    // element slots
    // ************************************************************

    for (genvar i = 0; i < MAX_ELS-1; i++)
    begin : g_slot

      assign we[i] = v_i & ~waiting & (count_r == len_t'(i));

      always_ff @(posedge clk_i)
      begin
        if (we[i] & ready_o)
          store_r[i] <= data_i;                     // captured on its transfer.
      end

      // the word being offered shows through right away.
      assign data_o[i] = we[i] ? data_i : store_r[i];

    end

    assign data_o[MAX_ELS-1] = data_i;              // top slot is only ever the last word.

  end

endmodule

`default_nettype wire

// ==== frame_join.sv ====
/*
  Joins two valid/ready streams into one.
  The joint output is valid only when both sides are valid, and each side
  sees ready only when its partner is valid too, so both complete in the
  same cycle. No payload passes through here. Purely combinational.
*/
`default_nettype none

module frame_join (
  // side a.
  input  logic a_v_i,
  output logic a_ready_o,

  // side b.
  input  logic b_v_i,
  output logic b_ready_o,

  // joined output.
  output logic v_o,
  input  logic ready_i
);

  // ************************************************************
  // joint handshake
  // ************************************************************

  assign v_o = a_v_i & b_v_i;

  // a side alone never sees ready, so it holds its burst.
  assign a_ready_o = ready_i & b_v_i;
  assign b_ready_o = ready_i & a_v_i;

endmodule

`default_nettype wire

// ==== burst_gather_top.sv ====
/*
  Two-lane burst gatherer: a data lane (1 to 4 words of 16 bits) and a
  tag lane (1 to 2 bytes) deserialize their bursts, then leave together
  as one frame. Lengths are count minus one and ride with the first word.
  A frame appears in the cycle the later lane offers its last word.
  One burst per lane is held; there is no error or framing recovery.
*/
`default_nettype none

module burst_gather_top (
  input  logic                                                clk_i,
  input  logic                                                rst_i,

  // data lane input.
  input  logic                                                data_v_i,
  input  gather_pkg::data_word_t                              data_i,
  input  gather_pkg::data_len_t                               data_len_i,
  output logic                                                data_ready_o,
  output logic                                                data_len_ready_o,

  // tag lane input.
  input  logic                                                tag_v_i,
  input  gather_pkg::tag_word_t                               tag_i,
  input  gather_pkg::tag_len_t                                tag_len_i,
  output logic                                                tag_ready_o,
  output logic                                                tag_len_ready_o,

  // joined frame.
  output logic                                                frame_v_o,
  output gather_pkg::data_word_t [gather_pkg::DATA_ELS-1:0]   frame_data_o,
  output gather_pkg::tag_word_t  [gather_pkg::TAG_ELS-1:0]    frame_tag_o,
  input  logic                                                frame_ready_i
);

  import gather_pkg::*;

  logic data_lane_v;
  logic data_lane_ready;
  logic tag_lane_v;
  logic tag_lane_ready;

  // ************************************************************
  // lanes
  // ************************************************************

  sipo_dynamic #(
    .elem_t  (data_word_t),
    .MAX_ELS (DATA_ELS)
  ) data_lane (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .v_i         (data_v_i),
    .data_i      (data_i),
    .len_i       (data_len_i),
    .ready_o     (data_ready_o),
    .len_ready_o (data_len_ready_o),
    .v_o         (data_lane_v),
    .data_o      (frame_data_o),
    .ready_i     (data_lane_ready)
  );

  sipo_dynamic #(
    .elem_t  (tag_word_t),
    .MAX_ELS (TAG_ELS)
  ) tag_lane (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .v_i         (tag_v_i),
    .data_i      (tag_i),
    .len_i       (tag_len_i),
    .ready_o     (tag_ready_o),
    .len_ready_o (tag_len_ready_o),
    .v_o         (tag_lane_v),
    .data_o      (frame_tag_o),
    .ready_i     (tag_lane_ready)
  );

  // ************************************************************
  // join
  // ************************************************************

  frame_join joiner (
    .a_v_i     (data_lane_v),
    .a_ready_o (data_lane_ready),
    .b_v_i     (tag_lane_v),
    .b_ready_o (tag_lane_ready),
    .v_o       (frame_v_o),
    .ready_i   (frame_ready_i)
  );

endmodule

`default_nettype wire

// ==== tb_burst_gather.sv ====
/*
  Self-checking testbench for the two-lane burst gatherer.
  Inputs change on the falling edge and outputs are checked on the rising edge.
  Each lane driver holds a word until the lane takes it.
  Expected frames are queued per lane at burst start and only elements
  0 through the burst length are compared.
*/
`default_nettype none

module tb_burst_gather;

  import gather_pkg::*;

  localparam int TIMEOUT = 200;   // cycles allowed for any single wait.
  localparam int FRAMES  = 300;

  typedef data_word_t [DATA_ELS-1:0] data_vec_t;
  typedef tag_word_t  [TAG_ELS-1:0]  tag_vec_t;

  logic       clk_i;
  logic       rst_i;
  logic       data_v_i;
  data_word_t data_i;
  data_len_t  data_len_i;
  logic       data_ready_o;
  logic       data_len_ready_o;
  logic       tag_v_i;
  tag_word_t  tag_i;
  tag_len_t   tag_len_i;
  logic       tag_ready_o;
  logic       tag_len_ready_o;
  logic       frame_v_o;
  data_vec_t  frame_data_o;
  tag_vec_t   frame_tag_o;
  logic       frame_ready_i;

  data_vec_t  exp_data_q[$];
  int         exp_dlen_q[$];
  tag_vec_t   exp_tag_q[$];
  int         exp_tlen_q[$];

  int         data_idx;         // element index the data driver is offering.
  int         data_len_cur;
  logic       data_last;
  int         tag_idx;
  int         tag_len_cur;
  logic       tag_last;
  logic       drivers_done;
  int         wait_n;

  burst_gather_top DUT (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ************************************************************
  // failure reporting
  // ************************************************************

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  task automatic timeout_expired(input string what);
    $display("timeout while waiting for %s", what);
    $display("Simulation failed");
    $fatal(1, "timeout");
  endtask

  // ************************************************************
  // assertions
  // ************************************************************

  // last word of a burst shows up on the frame with zero latency.
  a_data_last: assert property (@(posedge clk_i) disable iff (rst_i)
    data_v_i && data_last && (data_idx != 0 || data_len_ready_o)
    |-> DUT.data_lane_v && frame_data_o[data_len_cur] == data_i)
    else report_fail("data last word not presented in the same cycle");

  a_tag_last: assert property (@(posedge clk_i) disable iff (rst_i)
    tag_v_i && tag_last && (tag_idx != 0 || tag_len_ready_o)
    |-> DUT.tag_lane_v && frame_tag_o[tag_len_cur] == tag_i)
    else report_fail("tag last word not presented in the same cycle");

  a_hold_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    frame_v_o && !frame_ready_i |=> frame_v_o)
    else report_fail("frame valid dropped under back-pressure");

  a_hold_data: assert property (@(posedge clk_i) disable iff (rst_i)
    frame_v_o && !frame_ready_i |=> $stable(frame_data_o[0]) && $stable(frame_tag_o[0]))
    else report_fail("frame payload changed under back-pressure");

  // a single-word burst is still taken and parks in the waiting state.
  a_stall_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    frame_v_o && !frame_ready_i
    |-> (data_len_ready_o || !data_ready_o) && (tag_len_ready_o || !tag_ready_o))
    else report_fail("lane ready high while frame is stalled");

  // a finished tag burst waits for its data partner.
  a_skew: assert property (@(posedge clk_i) disable iff (rst_i)
    DUT.tag_lane_v && !DUT.data_lane_v && !tag_len_ready_o |-> !tag_ready_o)
    else report_fail("tag lane moved on without the data lane");

  a_data_start: assert property (@(posedge clk_i) disable iff (rst_i)
    data_v_i && data_ready_o |-> data_len_ready_o == (data_idx == 0))
    else report_fail("data_len_ready_o does not match burst start");

  a_tag_start: assert property (@(posedge clk_i) disable iff (rst_i)
    tag_v_i && tag_ready_o |-> tag_len_ready_o == (tag_idx == 0))
    else report_fail("tag_len_ready_o does not match burst start");

  // ************************************************************
  // frame monitor
  // ************************************************************

  // an offered frame must match the queue heads in every cycle it is held.
  always @(posedge clk_i)
  begin
    if (!rst_i && frame_v_o)
    begin
      if (exp_data_q.size() == 0 || exp_tag_q.size() == 0)
        report_fail("frame offered with no burst queued");
      for (int i = 0; i <= exp_dlen_q[0]; i++)
        assert (frame_data_o[i] == exp_data_q[0][i])
          else report_fail($sformatf("data element %0d is %h, expected %h",
                                     i, frame_data_o[i], exp_data_q[0][i]));
      for (int i = 0; i <= exp_tlen_q[0]; i++)
        assert (frame_tag_o[i] == exp_tag_q[0][i])
          else report_fail($sformatf("tag element %0d is %h, expected %h",
                                     i, frame_tag_o[i], exp_tag_q[0][i]));
      if (frame_ready_i)
      begin
        void'(exp_data_q.pop_front());
        void'(exp_dlen_q.pop_front());
        void'(exp_tag_q.pop_front());
        void'(exp_tlen_q.pop_front());
      end
    end
  end

  // ************************************************************
  // lane drivers
  // ************************************************************

  task automatic send_data(input int len, input int gap_max);
    data_vec_t words;
    int        n;
    for (int k = 0; k < DATA_ELS; k++)
      words[k] = data_word_t'($urandom);
    exp_data_q.push_back(words);
    exp_dlen_q.push_back(len);
    for (int k = 0; k <= len; k++)
    begin
      data_idx     = k;
      data_len_cur = len;
      data_last    = (k == len);
      data_v_i     = 1'b1;
      data_i       = words[k];
      data_len_i   = data_len_t'(len);
      n = 0;
      do
      begin
        @(posedge clk_i);
        n++;
        if (n > TIMEOUT)
          timeout_expired("data lane ready");
      end
      while (!data_ready_o);
      @(negedge clk_i);
      data_v_i  = 1'b0;
      data_last = 1'b0;
      if (gap_max > 0)
        repeat ($urandom % (gap_max + 1)) @(negedge clk_i);
    end
    data_idx = 0;
  endtask

  task automatic send_tag(input int len, input int gap_max);
    tag_vec_t words;
    int       n;
    for (int k = 0; k < TAG_ELS; k++)
      words[k] = tag_word_t'($urandom);
    exp_tag_q.push_back(words);
    exp_tlen_q.push_back(len);
    for (int k = 0; k <= len; k++)
    begin
      tag_idx     = k;
      tag_len_cur = len;
      tag_last    = (k == len);
      tag_v_i     = 1'b1;
      tag_i       = words[k];
      tag_len_i   = tag_len_t'(len);
      n = 0;
      do
      begin
        @(posedge clk_i);
        n++;
        if (n > TIMEOUT)
          timeout_expired("tag lane ready");
      end
      while (!tag_ready_o);
      @(negedge clk_i);
      tag_v_i  = 1'b0;
      tag_last = 1'b0;
      if (gap_max > 0)
        repeat ($urandom % (gap_max + 1)) @(negedge clk_i);
    end
    tag_idx = 0;
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial
  begin
    void'($urandom(47301));
    rst_i = 1'b1;
    data_v_i = 1'b0;
    data_i = '0;
    data_len_i = '0;
    tag_v_i = 1'b0;
    tag_i = '0;
    tag_len_i = '0;
    frame_ready_i = 1'b1;
    data_idx = 0;
    data_len_cur = 0;
    data_last = 1'b0;
    tag_idx = 0;
    tag_len_cur = 0;
    tag_last = 1'b0;
    drivers_done = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    assert (!frame_v_o && data_len_ready_o && tag_len_ready_o)
      else report_fail("wrong output state after reset");

    // full bursts, then single-word bursts on both lanes.
    fork
      send_data(3, 0);
      send_tag(1, 0);
    join
    fork
      send_data(0, 0);
      send_tag(0, 0);
    join

    // stalled output while both lanes hold a burst.
    frame_ready_i = 1'b0;
    fork
      send_data(2, 0);
      send_tag(1, 0);
      begin
        wait_n = 0;
        while (!frame_v_o)
        begin
          @(negedge clk_i);
          wait_n++;
          if (wait_n > TIMEOUT)
            timeout_expired("stalled frame valid");
        end
        repeat (4) @(negedge clk_i);
        frame_ready_i = 1'b1;
      end
    join

    // tag lane finishes well ahead of the data lane.
    fork
      send_tag(0, 0);
      begin
        repeat (5) @(negedge clk_i);
        send_data(3, 1);
      end
    join

    fork
      begin
        fork
          repeat (FRAMES) send_data($urandom % DATA_ELS, 2);
          repeat (FRAMES) send_tag($urandom % TAG_ELS, 2);
        join
        drivers_done = 1'b1;
      end
      while (!drivers_done)
      begin
        @(negedge clk_i);
        frame_ready_i = ($urandom % 4) != 0;
      end
    join
    @(negedge clk_i);
    frame_ready_i = 1'b1;

    wait_n = 0;
    while (exp_data_q.size() != 0 || exp_tag_q.size() != 0)
    begin
      @(negedge clk_i);
      wait_n++;
      if (wait_n > TIMEOUT)
        timeout_expired("queues to drain");
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
gather_pkg.sv
sipo_dynamic.sv
frame_join.sv
burst_gather_top.sv
tb_burst_gather.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the burst gatherer testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_burst_gather \
  -f vlog.f \
  -o sim_burst_gather
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/sim_burst_gather
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
